/* hw/dalu_defs.svh */
`ifndef DALU_DEFS_SVH
`define DALU_DEFS_SVH

// Width of the X and Y data buses and of every input register.
`define DATA_W 24
// The accumulator holds eight extension bits above two data words.
`define EXT_W 8
`define ACC_W 56

// Register source select. Codes 2 and 3 are reserved.
`define SRC_XDB 2'd0
`define SRC_YDB 2'd1

// Register select for the four input registers.
`define REG_X0 2'd0
`define REG_X1 2'd1
`define REG_Y0 2'd2
`define REG_Y1 2'd3

// Operation codes. Code 3 is reserved.
`define OP_MPY 2'd0
`define OP_MAC 2'd1
`define OP_CLR 2'd2

// Operand pair select for the multiplier.
`define QQ_X0Y0 2'd0
`define QQ_X1Y0 2'd1
`define QQ_X0Y1 2'd2
`define QQ_X1Y1 2'd3

// Limiter output values for positive and negative overflow.
`define LIM_POS 24'h7FFFFF
`define LIM_NEG 24'h800000

`endif

/* hw/dalu_pkg.sv */
`include "dalu_defs.svh"

package dalu_pkg;

	// The three portions of an accumulator, most significant first.
	// The extension byte holds the guard bits above the data word.
	typedef struct packed {
		logic [`EXT_W-1:0]  ext;
		logic [`DATA_W-1:0] msp;
		logic [`DATA_W-1:0] lsp;
	} acc_parts_t;

	// One accumulator word.
	// The arithmetic reads it as a single signed number.
	// The limiter and the bus readout read it by portion.
	typedef union packed {
		logic signed [`ACC_W-1:0] val;
		acc_parts_t               parts;
	} acc_word_t;

endpackage

/* hw/dalu_if.sv */
`timescale 1ns/100ps
`include "dalu_defs.svh"

// The four input registers as seen by the multiplier.
interface operand_if;

	logic [`DATA_W-1:0] x0;
	logic [`DATA_W-1:0] x1;
	logic [`DATA_W-1:0] y0;
	logic [`DATA_W-1:0] y1;

	// The register outputs drive the bundle.
	modport src (output x0, x1, y0, y1);
	// The multiplier only reads it.
	modport mac (input x0, x1, y0, y1);

endinterface

// Accumulator contents and the write port into them.
interface acc_if;

	import dalu_pkg::*;

	acc_word_t acc_a;
	acc_word_t acc_b;
	logic      wr_en;
	// Zero writes A and one writes B.
	logic      wr_dst;
	acc_word_t wr_value;

	modport file (output acc_a, acc_b, input wr_en, wr_dst, wr_value);
	modport mac (input acc_a, acc_b, output wr_en, wr_dst, wr_value);

endinterface

/* hw/xy_reg.sv */
`timescale 1ns/100ps
`include "dalu_defs.svh"

module xy_reg (
	input  logic              Clk,
	input  logic              reset,
	input  logic [`DATA_W-1:0] xdb,
	input  logic [`DATA_W-1:0] ydb,
	input  logic [1:0]        in_ctl,
	input  logic              write,
	output logic [`DATA_W-1:0] q
);

	logic [`DATA_W-1:0] mux_out;

	// Pick the source bus for the next load.
	// A reserved code feeds the current value back, so a stray write changes nothing.
	always_comb
	begin
		case (in_ctl)
			`SRC_XDB: mux_out = xdb;
			`SRC_YDB: mux_out = ydb;
			default:  mux_out = q;
		endcase
	end

	// The register loads only while the write strobe is high.
	always_ff @(posedge Clk or posedge reset)
	begin
		if (reset)
			q <= '0;
		else if (write)
			q <= mux_out;
	end

	// A write must name one of the two data buses.
	a_src_legal: assert property (@(posedge Clk) disable iff (reset)
		write |-> (in_ctl == `SRC_XDB || in_ctl == `SRC_YDB))
		else $error("xy_reg: write with reserved source code %0d", in_ctl);

endmodule

/* hw/mac_unit.sv */
`timescale 1ns/100ps
`include "dalu_defs.svh"

module mac_unit (
	input  logic       Clk,
	input  logic       reset,
	input  logic       op_valid,
	input  logic [1:0] op_code,
	input  logic [1:0] op_qq,
	input  logic       op_neg,
	input  logic       op_dst,
	operand_if.mac     opnd,
	acc_if.mac         acc
);

	import dalu_pkg::*;

	logic        [`DATA_W-1:0]   mul_a;
	logic        [`DATA_W-1:0]   mul_b;
	logic signed [2*`DATA_W-1:0] prod_full;
	logic signed [2*`DATA_W-1:0] prod_frac;

	logic                     s1_valid;
	logic [1:0]               s1_code;
	logic                     s1_neg;
	logic                     s1_dst;
	logic signed [`ACC_W-1:0] s1_prod;

	logic                     s2_valid;
	logic [1:0]               s2_code;
	logic                     s2_neg;
	logic                     s2_dst;
	logic signed [`ACC_W-1:0] s2_prod;

	acc_word_t                acc_old;
	acc_word_t                result;
	logic signed [`ACC_W-1:0] addend;

	// Operand pair for the multiplier, taken from the registers in the strobe cycle.
	always_comb
	begin
		case (op_qq)
			`QQ_X0Y0: {mul_a, mul_b} = {opnd.x0, opnd.y0};
			`QQ_X1Y0: {mul_a, mul_b} = {opnd.x1, opnd.y0};
			`QQ_X0Y1: {mul_a, mul_b} = {opnd.x0, opnd.y1};
			default:  {mul_a, mul_b} = {opnd.x1, opnd.y1};
		endcase
	end

	// Both operands are signed fractions, so the product is shifted left once.
	// The shift drops the redundant sign bit and keeps 48 bits.
	assign prod_full = $signed(mul_a) * $signed(mul_b);
	assign prod_frac = prod_full <<< 1;

	// Control state of both stages.
	always_ff @(posedge Clk or posedge reset)
	begin
		if (reset)
		begin
			s1_valid <= 1'b0;
			s1_code  <= `OP_MPY;
			s1_neg   <= 1'b0;
			s1_dst   <= 1'b0;
			s2_valid <= 1'b0;
			s2_code  <= `OP_MPY;
			s2_neg   <= 1'b0;
			s2_dst   <= 1'b0;
		end
		else
		begin
			s1_valid <= op_valid;
			s1_code  <= op_code;
			s1_neg   <= op_neg;
			s1_dst   <= op_dst;
			s2_valid <= s1_valid;
			s2_code  <= s1_code;
			s2_neg   <= s1_neg;
			s2_dst   <= s1_dst;
		end
	end

	// Product payload, sign-extended into the guard bits.
	always_ff @(posedge Clk or posedge reset)
	begin
		if (reset)
		begin
			s1_prod <= '0;
			s2_prod <= '0;
		end
		else
		begin
			s1_prod <= {{`EXT_W{prod_frac[2*`DATA_W-1]}}, prod_frac};
			s2_prod <= s1_prod;
		end
	end

	// Stage 2 reads the destination in the same cycle that it writes it.
	// An operation one cycle ahead has therefore already landed.
	assign acc_old = s2_dst ? acc.acc_b : acc.acc_a;
	assign addend  = s2_neg ? -s2_prod : s2_prod;

	always_comb
	begin
		result = acc_old;
		case (s2_code)
			`OP_MPY: result.val = addend;
			`OP_MAC: result.val = acc_old.val + addend;
			`OP_CLR: result.val = '0;
			default: result = acc_old;
		endcase
	end

	assign acc.wr_en    = s2_valid;
	assign acc.wr_dst   = s2_dst;
	assign acc.wr_value = result;

	a_op_code_legal: assert property (@(posedge Clk) disable iff (reset)
		op_valid |-> (op_code != 2'd3))
		else $error("mac_unit: reserved operation code");

	// Every accepted operation reaches the accumulators one cycle after stage 1.
	a_write_follows: assert property (@(posedge Clk) disable iff (reset)
		s1_valid |=> acc.wr_en);
	a_write_source: assert property (@(posedge Clk) disable iff (reset)
		acc.wr_en |-> $past(s1_valid));

endmodule

/* hw/acc_file.sv */
`timescale 1ns/100ps
`include "dalu_defs.svh"

module acc_file (
	input  logic               Clk,
	input  logic               reset,
	acc_if.file                acc,
	input  logic               rd_sel,
	output logic [`DATA_W-1:0] rd_data,
	output logic               rd_limited,
	output dalu_pkg::acc_word_t rd_acc
);

	import dalu_pkg::*;

	// Bounds of a 48-bit signed fraction held in the accumulator.
	localparam logic signed [`ACC_W-1:0] FIT_MAX = (`ACC_W'(1) <<< (2*`DATA_W-1)) - 1;
	localparam logic signed [`ACC_W-1:0] FIT_MIN = -(`ACC_W'(1) <<< (2*`DATA_W-1));

	acc_word_t sel_acc;
	logic      sign_bit;
	logic      ext_used;

	// Accumulators A and B.
	// A write from the multiplier lands at the next rising edge.
	always_ff @(posedge Clk or posedge reset)
	begin
		if (reset)
		begin
			acc.acc_a <= '0;
			acc.acc_b <= '0;
		end
		else if (acc.wr_en)
		begin
			if (acc.wr_dst)
				acc.acc_b <= acc.wr_value;
			else
				acc.acc_a <= acc.wr_value;
		end
	end

	// Readout is combinational from the selected accumulator.
	assign sel_acc = rd_sel ? acc.acc_b : acc.acc_a;
	assign rd_acc  = sel_acc;

	// The value fits the bus only when every extension bit copies the sign of msp.
	assign sign_bit = sel_acc.parts.msp[`DATA_W-1];
	assign ext_used = (sel_acc.parts.ext != {`EXT_W{sign_bit}});

	// On overflow the top bit of ext gives the true sign of the value.
	always_comb
	begin
		if (!ext_used)
			rd_data = sel_acc.parts.msp;
		else if (sel_acc.parts.ext[`EXT_W-1])
			rd_data = `LIM_NEG;
		else
			rd_data = `LIM_POS;
	end

	assign rd_limited = ext_used;

	// The limiter may act only on a value outside the range of a 48-bit fraction.
	a_limit_needs_ext: assert property (@(posedge Clk) disable iff (reset)
		rd_limited |-> (rd_acc.val > FIT_MAX || rd_acc.val < FIT_MIN))
		else $error("acc_file: limiter set while the extension matches the sign");

endmodule

/* hw/data_alu.sv */
`timescale 1ns/100ps
`include "dalu_defs.svh"

module data_alu (
	input  logic                Clk,
	input  logic                reset,
	input  logic [`DATA_W-1:0]  xdb,
	input  logic [`DATA_W-1:0]  ydb,
	input  logic                reg_write,
	input  logic [1:0]          reg_sel,
	input  logic [1:0]          reg_src,
	input  logic                op_valid,
	input  logic [1:0]          op_code,
	input  logic [1:0]          op_qq,
	input  logic                op_neg,
	input  logic                op_dst,
	input  logic                rd_sel,
	output logic [`DATA_W-1:0]  rd_data,
	output logic                rd_limited,
	output dalu_pkg::acc_word_t rd_acc
);

	// One write enable per input register, indexed by the register code.
	logic [3:0] reg_we;

	operand_if opnd ();
	acc_if     acc ();

	// Only the register named by reg_sel sees the write strobe.
	always_comb
	begin
		reg_we = '0;
		if (reg_write)
			reg_we[reg_sel] = 1'b1;
	end

	// All four registers share the source select and both data buses.
	xy_reg u_x0 (.Clk, .reset, .xdb, .ydb, .in_ctl(reg_src),
		.write(reg_we[`REG_X0]), .q(opnd.x0));
	xy_reg u_x1 (.Clk, .reset, .xdb, .ydb, .in_ctl(reg_src),
		.write(reg_we[`REG_X1]), .q(opnd.x1));
	xy_reg u_y0 (.Clk, .reset, .xdb, .ydb, .in_ctl(reg_src),
		.write(reg_we[`REG_Y0]), .q(opnd.y0));
	xy_reg u_y1 (.Clk, .reset, .xdb, .ydb, .in_ctl(reg_src),
		.write(reg_we[`REG_Y1]), .q(opnd.y1));

	mac_unit u_mac (
		.Clk,
		.reset,
		.op_valid,
		.op_code,
		.op_qq,
		.op_neg,
		.op_dst,
		.opnd (opnd.mac),
		.acc  (acc.mac)
	);

	acc_file u_acc (
		.Clk,
		.reset,
		.acc        (acc.file),
		.rd_sel,
		.rd_data,
		.rd_limited,
		.rd_acc
	);

endmodule

/* tb/tb_data_alu.sv */
`timescale 1ns/100ps
`include "dalu_defs.svh"

module tb_data_alu;

	import dalu_pkg::*;

	// Lengths of the tests; the watchdog budget is derived from them.
	localparam int N_MAC = 32;
	localparam int N_MIX = 60;
	localparam int N_OPS = 6 + 1 + N_MAC + 15 + 21 + N_MIX;
	localparam int N_WR = 5 + 4 + 3 + N_MIX;
	localparam int WATCHDOG_NS = (N_OPS + N_WR + 20) * 4 * 4;

	// One accepted operation and the edge count after which its result shows.
	typedef struct packed {
		int        due;
		logic      dst;
		acc_word_t val;
	} pend_t;

	logic Clk, reset, reg_write, op_valid, op_neg, op_dst, rd_sel, rd_limited;
	logic [`DATA_W-1:0] xdb, ydb, rd_data;
	logic [1:0] reg_sel, reg_src, op_code, op_qq;
	acc_word_t rd_acc;

	// Model state: registers and accumulators as seen at issue time.
	logic [`DATA_W-1:0] m_reg [4];
	acc_word_t m_acc [2];
	// Accumulators as the DUT should show them right now.
	acc_word_t shown [2];
	pend_t pend_q [$];
	logic [`DATA_W:0] exp_rd;
	int edge_cnt = 0;
	logic checking = 1'b0;
	int acc_errs = 0;
	int bus_errs = 0;
	int flag_errs = 0;
	int timeout_errs = 0;

	data_alu u_data_alu (.Clk, .reset, .xdb, .ydb, .reg_write, .reg_sel, .reg_src,
		.op_valid, .op_code, .op_qq, .op_neg, .op_dst, .rd_sel, .rd_data, .rd_limited, .rd_acc);

	always #2 Clk = ~Clk;

	always @(posedge Clk)
	begin
		edge_cnt <= edge_cnt + 1;
	end

	// Expected accumulator after one operation.
	// The product is the signed product doubled, kept to 48 bits and sign-extended.
	function automatic acc_word_t ref_result(input logic [1:0] code, input logic neg,
			input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b, input acc_word_t old);
		logic signed [`ACC_W-1:0] ea;
		logic signed [`ACC_W-1:0] eb;
		logic signed [`ACC_W-1:0] term;
		logic [2*`DATA_W-1:0] p48;
		acc_word_t r;
		ea = {{32{a[`DATA_W-1]}}, a};
		eb = {{32{b[`DATA_W-1]}}, b};
		term = ea * eb;
		p48 = {term[2*`DATA_W-2:0], 1'b0};
		term = {{`EXT_W{p48[2*`DATA_W-1]}}, p48};
		if (neg)
			term = -term;
		r = old;
		case (code)
			`OP_MPY: r.val = term;
			`OP_MAC: r.val = old.val + term;
			`OP_CLR: r.val = '0;
			default: r = old;
		endcase
		return r;
	endfunction

	// Expected limiter output as {rd_limited, rd_data}.
	// A value beyond the range of a 48-bit fraction saturates toward its sign.
	function automatic logic [`DATA_W:0] ref_limit(input acc_word_t w);
		logic signed [`ACC_W-1:0] top;
		top = `ACC_W'(1) <<< (2*`DATA_W-1);
		if (w.val >= top)
			return {1'b1, `LIM_POS};
		else if (w.val < -top)
			return {1'b1, `LIM_NEG};
		else
			return {1'b0, w.parts.msp};
	endfunction

	task automatic check_acc(input string name, input acc_word_t exp, input acc_word_t act);
		if (exp !== act)
		begin
			$display("[FAIL] %s expected %h got %h at %0t", name, exp, act, $time);
			acc_errs++;
		end
	endtask

	task automatic check_bus(input string name, input logic [`DATA_W-1:0] exp,
			input logic [`DATA_W-1:0] act);
		if (exp !== act)
		begin
			$display("[FAIL] %s expected %h got %h at %0t", name, exp, act, $time);
			bus_errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("[FAIL] %s expected %h got %h at %0t", name, exp, act, $time);
			flag_errs++;
		end
	endtask

	// Drives one cycle of inputs and updates the model.
	task automatic drive_cycle(input logic do_wr, input logic [1:0] sel, input logic [1:0] src,
			input logic [`DATA_W-1:0] xv, input logic [`DATA_W-1:0] yv, input logic do_op,
			input logic [1:0] code, input logic [1:0] qq, input logic neg, input logic dst);
		pend_t entry;
		xdb = xv;
		ydb = yv;
		reg_write = do_wr;
		reg_sel = sel;
		reg_src = src;
		op_valid = do_op;
		op_code = code;
		op_qq = qq;
		op_neg = neg;
		op_dst = dst;
		// An operation reads the registers before a write in the same cycle lands.
		if (do_op)
		begin
			m_acc[dst] = ref_result(code, neg, m_reg[qq[0] ? `REG_X1 : `REG_X0],
				m_reg[qq[1] ? `REG_Y1 : `REG_Y0], m_acc[dst]);
			entry.due = edge_cnt + 3;
			entry.dst = dst;
			entry.val = m_acc[dst];
			pend_q.push_back(entry);
		end
		if (do_wr)
			m_reg[sel] = (src == `SRC_XDB) ? xv : yv;
		@(posedge Clk);
		#1;
	endtask

	// The unused bus carries noise, so a wrong source select shows up.
	task automatic write_reg(input logic [1:0] sel, input logic [1:0] src,
			input logic [`DATA_W-1:0] value);
		logic [`DATA_W-1:0] noise;
		noise = `DATA_W'($urandom);
		if (src == `SRC_XDB)
			drive_cycle(1'b1, sel, src, value, noise, 1'b0, `OP_MPY, 2'd0, 1'b0, 1'b0);
		else
			drive_cycle(1'b1, sel, src, noise, value, 1'b0, `OP_MPY, 2'd0, 1'b0, 1'b0);
	endtask

	task automatic run_op(input logic [1:0] code, input logic [1:0] qq, input logic neg,
			input logic dst);
		drive_cycle(1'b0, 2'd0, `SRC_XDB, `DATA_W'($urandom), `DATA_W'($urandom), 1'b1,
			code, qq, neg, dst);
	endtask

	task automatic idle(input int n);
		reg_write = 1'b0;
		op_valid = 1'b0;
		repeat (n)
		begin
			@(posedge Clk);
			#1;
		end
	endtask

	task automatic report();
		$display("Errors: acc %0d, bus %0d, flag %0d, timeout %0d",
			acc_errs, bus_errs, flag_errs, timeout_errs);
		if (acc_errs + bus_errs + flag_errs + timeout_errs == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
	endtask

	// Results land in the shown state on their due edge; the selected one is compared.
	always @(negedge Clk)
	begin
		if (checking)
		begin
			while (pend_q.size() > 0 && pend_q[0].due <= edge_cnt)
			begin
				shown[pend_q[0].dst] = pend_q[0].val;
				void'(pend_q.pop_front());
			end
			exp_rd = ref_limit(shown[rd_sel]);
			check_acc("rd_acc", shown[rd_sel], rd_acc);
			check_bus("rd_data", exp_rd[`DATA_W-1:0], rd_data);
			check_flag("rd_limited", exp_rd[`DATA_W], rd_limited);
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run was still going after %0d ns and was stopped.", WATCHDOG_NS);
		timeout_errs++;
		report();
		$finish;
	end

	initial
	begin
		void'($urandom(36));
		Clk = 1'b0;
		reset = 1'b1;
		{xdb, ydb, reg_write, reg_sel, reg_src, rd_sel} = '0;
		{op_valid, op_code, op_qq, op_neg, op_dst} = '0;
		m_reg = '{default: '0};
		m_acc = '{default: '0};
		shown = '{default: '0};
		repeat (8) @(posedge Clk);
		#1;
		reset = 1'b0;
		checking = 1'b1;

		// Both accumulators read as zero after reset.
		for (int s = 0; s < 2; s++)
		begin
			rd_sel = s[0];
			idle(1);
			check_acc("rd_acc", '0, rd_acc);
			check_bus("rd_data", '0, rd_data);
			check_flag("rd_limited", 1'b0, rd_limited);
		end

		// Loads from both buses, then every operand pair.
		write_reg(`REG_X0, `SRC_XDB, 24'h400000);
		write_reg(`REG_X1, `SRC_YDB, 24'hC00000);
		write_reg(`REG_Y0, `SRC_XDB, 24'h200000);
		write_reg(`REG_Y1, `SRC_YDB, 24'h123456);
		rd_sel = 1'b0;
		for (int q = 0; q < 4; q++)
			run_op(`OP_MPY, 2'(q), 1'b0, 1'b0);
		// X1 changes; X0 and Y0 must still hold.
		write_reg(`REG_X1, `SRC_XDB, 24'h7ABCDE);
		run_op(`OP_MPY, `QQ_X1Y1, 1'b0, 1'b0);
		run_op(`OP_MPY, `QQ_X0Y0, 1'b0, 1'b0);
		idle(3);

		// Back-to-back MACs into A chain through the pipeline.
		for (int r = 0; r < 4; r++)
			write_reg(2'(r), 2'($urandom % 2), `DATA_W'($urandom));
		run_op(`OP_CLR, `QQ_X0Y0, 1'b0, 1'b0);
		for (int i = 0; i < N_MAC; i++)
			run_op(`OP_MAC, 2'($urandom), 1'($urandom), 1'b0);
		idle(3);

		// A and B interleaved, then a CLR to each in turn.
		for (int i = 0; i < 15; i++)
		begin
			rd_sel = ~rd_sel;
			if (i < 12)
				run_op(`OP_MAC, 2'($urandom), 1'($urandom), 1'(i));
			else
				run_op((i == 13) ? `OP_MAC : `OP_CLR, `QQ_X0Y0, 1'b0, i != 12);
		end
		idle(3);

		// Products near plus one and minus one drive A past the data range.
		rd_sel = 1'b0;
		write_reg(`REG_X0, `SRC_XDB, `LIM_POS);
		write_reg(`REG_Y0, `SRC_YDB, `LIM_POS);
		write_reg(`REG_Y1, `SRC_XDB, `LIM_NEG);
		run_op(`OP_CLR, `QQ_X0Y0, 1'b0, 1'b0);
		repeat (6) run_op(`OP_MAC, `QQ_X0Y0, 1'b0, 1'b0);
		idle(3);
		check_bus("rd_data", `LIM_POS, rd_data);
		check_flag("rd_limited", 1'b1, rd_limited);
		check_acc("rd_acc", m_acc[0], rd_acc);
		repeat (14) run_op(`OP_MAC, `QQ_X0Y1, 1'b0, 1'b0);
		idle(3);
		check_bus("rd_data", `LIM_NEG, rd_data);
		check_flag("rd_limited", 1'b1, rd_limited);
		check_acc("rd_acc", m_acc[0], rd_acc);

		// Random mix of writes, operations and readout selects.
		for (int i = 0; i < N_MIX; i++)
		begin
			rd_sel = 1'($urandom);
			drive_cycle(1'($urandom), 2'($urandom), 2'($urandom % 2), `DATA_W'($urandom),
				`DATA_W'($urandom), 1'($urandom), 2'($urandom % 3), 2'($urandom),
				1'($urandom), 1'($urandom));
		end
		idle(4);
		report();
		$finish;
	end

endmodule

/* sim.f */
+incdir+hw
hw/dalu_pkg.sv
hw/dalu_if.sv
hw/xy_reg.sv
hw/mac_unit.sv
hw/acc_file.sv
hw/data_alu.sv
tb/tb_data_alu.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -f sim.f --top-module tb_data_alu -o tb_data_alu \
	> "$LOG" 2>&1 && ./obj_dir/tb_data_alu >> "$LOG" 2>&1 \
	|| echo "Build or simulation did not complete." >> "$LOG"
cat "$LOG"
grep -q ">>> FAIL" "$LOG" && exit 1
grep -q ">>> PASS" "$LOG" || exit 1
exit 0
